// File: compile.f
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/ctrl_decode.sv
source/operand_decode.sv
source/reg_file.sv
source/alu_exec.sv
source/commit_unit.sv
source/rv32_core.sv
bench/tb_rv32_core.sv

// File: Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv32_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_rv32_core.sv
// testbench for the RV32I core, runs a fixed instruction trace from a table and checks each retire
`timescale 1ns/1ps

module tb_rv32_core;

    localparam int          NUM_TESTS    = 43;
    localparam int          RESET_CYCLES = 3;
    localparam int          CYCLE_LIMIT  = NUM_TESTS + RESET_CYCLES + 20;
    localparam logic [31:0] RESET_PC     = 32'h0000_0000;

    // --------------------
    // isa encodings
    // --------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    logic        clk_i;
    logic        rst_i;
    logic [31:0] inst_i;
    logic [31:0] pc_o;
    logic        wb_en_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;
    logic        illegal_o;

    // program trace, one row per retired instruction
    string       test_name [NUM_TESTS];
    logic [31:0] prog_inst [NUM_TESTS];
    logic [31:0] exp_pc    [NUM_TESTS];
    logic        exp_en    [NUM_TESTS];
    logic [4:0]  exp_addr  [NUM_TESTS];
    logic [31:0] exp_data  [NUM_TESTS];
    logic        exp_ill   [NUM_TESTS];

    int row_count;
    int pass_count;
    int fail_count;
    int cycles;
    bit row_ok;

    rv32_core #(
        .RESET_PC   (RESET_PC)
    ) DUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .inst_i     (inst_i),
        .pc_o       (pc_o),
        .wb_en_o    (wb_en_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .illegal_o  (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    // --------------------
    // instruction encoders
    // --------------------
    function automatic logic [31:0] enc_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1,
                                          input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst, input int pc,
                           input int en, input int addr, input logic [31:0] data,
                           input int ill);
        if (row_count < NUM_TESTS) begin
            test_name[row_count] = name;
            prog_inst[row_count] = inst;
            exp_pc[row_count]    = pc;
            exp_en[row_count]    = (en != 0);
            exp_addr[row_count]  = addr[4:0];
            exp_data[row_count]  = data;
            exp_ill[row_count]   = (ill != 0);
        end
        row_count++;
    endtask

    task automatic log_result(input string name, input bit ok);
        $display("test %-14s %s", name, ok ? "ok" : "error");
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    // x1=-5 x2=12 feed most of the alu and branch rows
    task automatic load_program();
        add_row("addi_neg", enc_i(OPC_OP_IMM, F3_ADD, 1, 0, -5), 0, 1, 1, 32'hffff_fffb, 0);
        add_row("addi_pos", enc_i(OPC_OP_IMM, F3_ADD, 2, 0, 12), 4, 1, 2, 32'h0000_000c, 0);
        add_row("add", enc_op(7'h00, F3_ADD, 3, 1, 2), 8, 1, 3, 32'h0000_0007, 0);
        add_row("sub", enc_op(7'h20, F3_ADD, 4, 1, 2), 12, 1, 4, 32'hffff_ffef, 0);
        add_row("slt", enc_op(7'h00, F3_SLT, 5, 1, 2), 16, 1, 5, 32'h0000_0001, 0);
        add_row("sltu", enc_op(7'h00, F3_SLTU, 6, 1, 2), 20, 1, 6, 32'h0000_0000, 0);
        add_row("slli", enc_i(OPC_OP_IMM, F3_SLL, 7, 2, 4), 24, 1, 7, 32'h0000_00c0, 0);
        add_row("srai_neg", enc_i(OPC_OP_IMM, F3_SR, 8, 1, 'h401), 28, 1, 8, 32'hffff_fffd, 0);
        add_row("srli_neg", enc_i(OPC_OP_IMM, F3_SR, 9, 1, 4), 32, 1, 9, 32'h0fff_ffff, 0);
        add_row("sra_neg", enc_op(7'h20, F3_SR, 10, 4, 5), 36, 1, 10, 32'hffff_fff7, 0);
        add_row("srl", enc_op(7'h00, F3_SR, 11, 4, 2), 40, 1, 11, 32'h000f_ffff, 0);
        add_row("sll", enc_op(7'h00, F3_SLL, 12, 2, 5), 44, 1, 12, 32'h0000_0018, 0);
        add_row("xor", enc_op(7'h00, F3_XOR, 13, 1, 2), 48, 1, 13, 32'hffff_fff7, 0);
        add_row("or", enc_op(7'h00, F3_OR, 14, 1, 2), 52, 1, 14, 32'hffff_ffff, 0);
        add_row("and", enc_op(7'h00, F3_AND, 15, 1, 2), 56, 1, 15, 32'h0000_0008, 0);
        add_row("xori_neg", enc_i(OPC_OP_IMM, F3_XOR, 16, 2, -1), 60, 1, 16, 32'hffff_fff3, 0);
        add_row("andi", enc_i(OPC_OP_IMM, F3_AND, 17, 1, 'hf0), 64, 1, 17, 32'h0000_00f0, 0);
        add_row("slti", enc_i(OPC_OP_IMM, F3_SLT, 18, 1, -4), 68, 1, 18, 32'h0000_0001, 0);
        add_row("sltiu", enc_i(OPC_OP_IMM, F3_SLTU, 19, 2, -1), 72, 1, 19, 32'h0000_0001, 0);
        add_row("addi_x0", enc_i(OPC_OP_IMM, F3_ADD, 0, 2, 5), 76, 1, 0, 32'h0000_0011, 0);
        add_row("read_x0", enc_op(7'h00, F3_ADD, 20, 0, 2), 80, 1, 20, 32'h0000_000c, 0);
        add_row("lui", enc_u(OPC_LUI, 21, 'h12345), 84, 1, 21, 32'h1234_5000, 0);
        add_row("auipc", enc_u(OPC_AUIPC, 22, 'h1), 88, 1, 22, 32'h0000_1058, 0);
        add_row("lui_high", enc_u(OPC_LUI, 23, 'hfffff), 92, 1, 23, 32'hffff_f000, 0);
        // branches, next row's pc shows the outcome
        add_row("beq_taken", enc_b(F3_BEQ, 3, 3, 8), 96, 0, 0, 32'h0, 0);
        add_row("beq_not", enc_b(F3_BEQ, 1, 2, 8), 104, 0, 0, 32'h0, 0);
        add_row("bne_taken", enc_b(F3_BNE, 1, 2, 12), 108, 0, 0, 32'h0, 0);
        add_row("bne_not", enc_b(F3_BNE, 2, 2, 8), 120, 0, 0, 32'h0, 0);
        add_row("blt_taken", enc_b(F3_BLT, 1, 2, 8), 124, 0, 0, 32'h0, 0);
        add_row("blt_not", enc_b(F3_BLT, 2, 1, 8), 132, 0, 0, 32'h0, 0);
        add_row("bge_taken", enc_b(F3_BGE, 2, 1, 8), 136, 0, 0, 32'h0, 0);
        add_row("bge_not", enc_b(F3_BGE, 1, 2, 8), 144, 0, 0, 32'h0, 0);
        add_row("bltu_taken", enc_b(F3_BLTU, 2, 1, 8), 148, 0, 0, 32'h0, 0);
        add_row("bltu_not", enc_b(F3_BLTU, 1, 2, 8), 156, 0, 0, 32'h0, 0);
        add_row("bgeu_back", enc_b(F3_BGEU, 1, 2, -48), 160, 0, 0, 32'h0, 0);
        add_row("bgeu_not", enc_b(F3_BGEU, 6, 2, 8), 112, 0, 0, 32'h0, 0);
        add_row("jal", enc_j(24, 52), 116, 1, 24, 32'h0000_0078, 0);
        add_row("jalr_odd", enc_i(OPC_JALR, 3'b000, 25, 24, 81), 168, 1, 25, 32'h0000_00ac, 0);
        // illegal words retire as pc+4 with no write
        add_row("ill_zero", 32'h0000_0000, 200, 0, 0, 32'h0, 1);
        add_row("ill_funct7", enc_op(7'h01, F3_ADD, 26, 1, 2), 204, 0, 0, 32'h0, 1);
        add_row("ill_slli", enc_i(OPC_OP_IMM, F3_SLL, 27, 2, 'h404), 208, 0, 0, 32'h0, 1);
        add_row("no_ill_wr", enc_op(7'h00, F3_ADD, 27, 26, 25), 212, 1, 27, 32'h0000_00ac, 0);
        add_row("link_sum", enc_op(7'h00, F3_ADD, 28, 24, 25), 216, 1, 28, 32'h0000_0124, 0);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_i      = 1'b1;
        inst_i     = enc_i(OPC_OP_IMM, F3_ADD, 1, 0, 7);
        row_count  = 0;
        pass_count = 0;
        fail_count = 0;
        load_program();
        if (row_count != NUM_TESTS) begin
            $display("program table holds %0d rows but %0d were expected", row_count, NUM_TESTS);
            fail_count++;
        end

        // writeback stays gated while reset is high
        row_ok = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            if (pc_o !== RESET_PC) begin
                $display("CHECK FAILED reset pc expected %h actual %h", RESET_PC, pc_o);
                row_ok = 1'b0;
            end
            if (wb_en_o !== 1'b0) begin
                $display("CHECK FAILED reset wb_en expected %h actual %h", 1'b0, wb_en_o);
                row_ok = 1'b0;
            end
        end
        log_result("reset", row_ok);
        rst_i = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            if (i > 0) begin
                @(negedge clk_i);
            end
            inst_i = prog_inst[i];
            #2;
            row_ok = 1'b1;
            if (pc_o !== exp_pc[i]) begin
                $display("CHECK FAILED %s pc expected %h actual %h", test_name[i], exp_pc[i], pc_o);
                row_ok = 1'b0;
            end
            if (illegal_o !== exp_ill[i]) begin
                $display("CHECK FAILED %s illegal expected %h actual %h", test_name[i],
                         exp_ill[i], illegal_o);
                row_ok = 1'b0;
            end
            if (wb_en_o !== exp_en[i]) begin
                $display("CHECK FAILED %s wb_en expected %h actual %h", test_name[i],
                         exp_en[i], wb_en_o);
                row_ok = 1'b0;
            end
            // address and data only mean something with a write
            if (exp_en[i] && (wb_addr_o !== exp_addr[i])) begin
                $display("CHECK FAILED %s wb_addr expected %0d actual %0d", test_name[i],
                         exp_addr[i], wb_addr_o);
                row_ok = 1'b0;
            end
            if (exp_en[i] && (wb_data_o !== exp_data[i])) begin
                $display("CHECK FAILED %s wb_data expected %h actual %h", test_name[i],
                         exp_data[i], wb_data_o);
                row_ok = 1'b0;
            end
            log_result(test_name[i], row_ok);
        end

        $display("summary: %0d tests, %0d passed, %0d failed", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: source/rv32_core.sv
// single-cycle RV32I core top, instruction fetched externally at pc_o every clock
`timescale 1ns/1ps

module rv32_core #(
    parameter logic [rv_ctrl_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]        inst_i,
    output logic [rv_ctrl_pkg::XLEN-1:0]        pc_o,
    output logic                                wb_en_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   wb_addr_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]        wb_data_o,
    output logic                                illegal_o
);

    // --------------------
    // control levels
    // --------------------
    rv_ctrl_pkg::op1_sel_e  op1_sel;
    rv_ctrl_pkg::op2_sel_e  op2_sel;
    rv_ctrl_pkg::alu_op_e   alu_op;
    rv_ctrl_pkg::wb_sel_e   wb_sel;
    rv_ctrl_pkg::br_kind_e  br_kind;
    logic                   wb_en;

    // datapath
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_ctrl_pkg::XLEN-1:0]      rs1_data;
    logic [rv_ctrl_pkg::XLEN-1:0]      rs2_data;
    logic [rv_ctrl_pkg::XLEN-1:0]      op1;
    logic [rv_ctrl_pkg::XLEN-1:0]      op2;
    logic [rv_ctrl_pkg::XLEN-1:0]      alu_result;
    logic [rv_ctrl_pkg::XLEN-1:0]      jalr_target;
    logic [rv_ctrl_pkg::XLEN-1:0]      br_target;
    logic [rv_ctrl_pkg::XLEN-1:0]      jal_target;
    logic                              br_eq;
    logic                              br_lt;
    logic                              br_ltu;

    ctrl_decode u_ctrl_decode (
        .inst_i     (inst_i),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .alu_op_o   (alu_op),
        .wb_sel_o   (wb_sel),
        .br_kind_o  (br_kind),
        .wb_en_o    (wb_en),
        .illegal_o  (illegal_o)
    );

    operand_decode u_operand_decode (
        .inst_i         (inst_i),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .pc_i           (pc_o),
        .op1_sel_i      (op1_sel),
        .op2_sel_i      (op2_sel),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rd_addr_o      (wb_addr_o),
        .op1_o          (op1),
        .op2_o          (op2),
        .jalr_target_o  (jalr_target),
        .br_target_o    (br_target),
        .jal_target_o   (jal_target),
        .br_eq_o        (br_eq),
        .br_lt_o        (br_lt),
        .br_ltu_o       (br_ltu)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_en_o),
        .wd_addr_i  (wb_addr_o),
        .wd_data_i  (wb_data_o)
    );

    alu_exec u_alu_exec (
        .alu_op_i   (alu_op),
        .op1_i      (op1),
        .op2_i      (op2),
        .result_o   (alu_result)
    );

    commit_unit #(
        .RESET_PC   (RESET_PC)
    ) u_commit_unit (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .br_kind_i      (br_kind),
        .wb_sel_i       (wb_sel),
        .wb_en_i        (wb_en),
        .br_eq_i        (br_eq),
        .br_lt_i        (br_lt),
        .br_ltu_i       (br_ltu),
        .alu_result_i   (alu_result),
        .jalr_target_i  (jalr_target),
        .br_target_i    (br_target),
        .jal_target_i   (jal_target),
        .pc_o           (pc_o),
        .wb_data_o      (wb_data_o),
        .wb_we_o        (wb_en_o)
    );

endmodule

// File: source/commit_unit.sv
// result stage, owns the pc, resolves branches and picks the writeback value
`timescale 1ns/1ps

module commit_unit #(
    parameter logic [rv_ctrl_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  rv_ctrl_pkg::br_kind_e           br_kind_i,
    input  rv_ctrl_pkg::wb_sel_e            wb_sel_i,
    input  logic                            wb_en_i,
    input  logic                            br_eq_i,
    input  logic                            br_lt_i,
    input  logic                            br_ltu_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]    alu_result_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]    jalr_target_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]    br_target_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]    jal_target_i,
    output logic [rv_ctrl_pkg::XLEN-1:0]    pc_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]    wb_data_o,
    output logic                            wb_we_o
);

    logic [rv_ctrl_pkg::XLEN-1:0] pc_plus4;
    logic [rv_ctrl_pkg::XLEN-1:0] next_pc;

    assign pc_plus4 = pc_o + 32'd4;

    always_comb begin
        case (br_kind_i)
            rv_ctrl_pkg::BR_EQ:   next_pc = br_eq_i   ? br_target_i : pc_plus4;
            rv_ctrl_pkg::BR_NE:   next_pc = !br_eq_i  ? br_target_i : pc_plus4;
            rv_ctrl_pkg::BR_LT:   next_pc = br_lt_i   ? br_target_i : pc_plus4;
            rv_ctrl_pkg::BR_GE:   next_pc = !br_lt_i  ? br_target_i : pc_plus4;
            rv_ctrl_pkg::BR_LTU:  next_pc = br_ltu_i  ? br_target_i : pc_plus4;
            rv_ctrl_pkg::BR_GEU:  next_pc = !br_ltu_i ? br_target_i : pc_plus4;
            rv_ctrl_pkg::BR_JAL:  next_pc = jal_target_i;
            rv_ctrl_pkg::BR_JALR: next_pc = jalr_target_i;
            default:              next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= RESET_PC;
        end else begin
            pc_o <= next_pc;
        end
    end

    // link address for jumps
    assign wb_data_o = (wb_sel_i == rv_ctrl_pkg::WB_PC4) ? pc_plus4 : alu_result_i;
    assign wb_we_o   = wb_en_i && !rst_i;

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        pc_o[1:0] == 2'b00);

endmodule

// File: source/alu_exec.sv
// execute stage, one combinational ALU for arithmetic, logic, shift and compare
`timescale 1ns/1ps

module alu_exec (
    input  rv_ctrl_pkg::alu_op_e            alu_op_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]    op1_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]    op2_i,
    output logic [rv_ctrl_pkg::XLEN-1:0]    result_o
);

    logic [4:0] shamt;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (alu_op_i)
            rv_ctrl_pkg::ALU_ADD:   result_o = op1_i + op2_i;
            rv_ctrl_pkg::ALU_SUB:   result_o = op1_i - op2_i;
            rv_ctrl_pkg::ALU_SLL:   result_o = op1_i << shamt;
            rv_ctrl_pkg::ALU_SRL:   result_o = op1_i >> shamt;
            rv_ctrl_pkg::ALU_SRA:   result_o = $unsigned($signed(op1_i) >>> shamt);
            // compares give 0 or 1
            rv_ctrl_pkg::ALU_SLT:   result_o = {31'd0, $signed(op1_i) < $signed(op2_i)};
            rv_ctrl_pkg::ALU_SLTU:  result_o = {31'd0, op1_i < op2_i};
            rv_ctrl_pkg::ALU_XOR:   result_o = op1_i ^ op2_i;
            rv_ctrl_pkg::ALU_OR:    result_o = op1_i | op2_i;
            rv_ctrl_pkg::ALU_AND:   result_o = op1_i & op2_i;
            rv_ctrl_pkg::ALU_COPY1: result_o = op1_i;
            default:                result_o = '0;
        endcase
    end

endmodule

// File: source/reg_file.sv
// integer register file with x0 reading as zero, two combinational reads and one clocked write
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs1_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs2_addr_i,
    output logic [rv_ctrl_pkg::XLEN-1:0]        rs1_data_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]        rs2_data_o,
    input  logic                                we_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]   wd_addr_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]        wd_data_i
);

    // x1..x31 only as x0 has no storage
    logic [rv_ctrl_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wd_addr_i != '0) begin
            regs[wd_addr_i] <= wd_data_i;
        end
    end

    // reads see the value from before this cycle's write
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // a register written in one cycle reads back on either port in the next
    a_write_reads_back: assert property (@(posedge clk_i) disable iff (rst_i)
        (we_i && wd_addr_i != '0) |=>
            ((rs1_addr_i != $past(wd_addr_i) || rs1_data_o == $past(wd_data_i)) &&
             (rs2_addr_i != $past(wd_addr_i) || rs2_data_o == $past(wd_data_i))));

endmodule

// File: source/operand_decode.sv
// operand stage of the core: register fields, immediates, jump targets, branch compares, operand muxes
`timescale 1ns/1ps

module operand_decode (
    input  rv_isa_pkg::inst_u                       inst_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]            rs1_data_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]            rs2_data_i,
    input  logic [rv_ctrl_pkg::XLEN-1:0]            pc_i,
    input  rv_ctrl_pkg::op1_sel_e                   op1_sel_i,
    input  rv_ctrl_pkg::op2_sel_e                   op2_sel_i,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]       rs1_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]       rs2_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]       rd_addr_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]            op1_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]            op2_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]            jalr_target_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]            br_target_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]            jal_target_o,
    output logic                                    br_eq_o,
    output logic                                    br_lt_o,
    output logic                                    br_ltu_o
);

    logic [rv_ctrl_pkg::XLEN-1:0] imm_i;
    logic [rv_ctrl_pkg::XLEN-1:0] imm_b;
    logic [rv_ctrl_pkg::XLEN-1:0] imm_u;
    logic [rv_ctrl_pkg::XLEN-1:0] imm_j;

    assign rs1_addr_o = inst_i.r.rs1;
    assign rs2_addr_o = inst_i.r.rs2;
    assign rd_addr_o  = inst_i.r.rd;

    // --------------------
    // immediates
    // --------------------
    assign imm_i = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
    assign imm_b = {{20{inst_i.b.imm_12}}, inst_i.b.imm_11, inst_i.b.imm_10_5,
                    inst_i.b.imm_4_1, 1'b0};
    assign imm_u = {inst_i.u.imm_31_12, 12'h000};
    assign imm_j = {{12{inst_i.j.imm_20}}, inst_i.j.imm_19_12, inst_i.j.imm_11,
                    inst_i.j.imm_10_1, 1'b0};

    // targets, jalr drops bit 0
    assign jalr_target_o = (rs1_data_i + imm_i) & ~32'd1;
    assign br_target_o   = pc_i + imm_b;
    assign jal_target_o  = pc_i + imm_j;

    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

    // --------------------
    // operand select
    // --------------------
    always_comb begin
        case (op1_sel_i)
            rv_ctrl_pkg::OP1_IMM_U: op1_o = imm_u;
            default:                op1_o = rs1_data_i;
        endcase
        case (op2_sel_i)
            rv_ctrl_pkg::OP2_PC:    op2_o = pc_i;
            rv_ctrl_pkg::OP2_IMM_I: op2_o = imm_i;
            default:                op2_o = rs2_data_i;
        endcase
    end

endmodule

// File: source/ctrl_decode.sv
// combinational main decoder that turns opcode and funct fields into the core's control levels
`timescale 1ns/1ps

module ctrl_decode (
    input  rv_isa_pkg::inst_u       inst_i,
    output rv_ctrl_pkg::op1_sel_e   op1_sel_o,
    output rv_ctrl_pkg::op2_sel_e   op2_sel_o,
    output rv_ctrl_pkg::alu_op_e    alu_op_o,
    output rv_ctrl_pkg::wb_sel_e    wb_sel_o,
    output rv_ctrl_pkg::br_kind_e   br_kind_o,
    output logic                    wb_en_o,
    output logic                    illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_op;
    logic       f7_base;
    logic       f7_alt;

    assign opcode  = inst_i.r.opcode;
    assign funct3  = inst_i.r.funct3;
    assign is_op   = (opcode == rv_isa_pkg::OPC_OP);
    assign f7_base = (inst_i.r.funct7 == rv_isa_pkg::F7_BASE);
    assign f7_alt  = (inst_i.r.funct7 == rv_isa_pkg::F7_ALT);

    always_comb begin
        op1_sel_o = rv_ctrl_pkg::OP1_RS1;
        op2_sel_o = rv_ctrl_pkg::OP2_RS2;
        alu_op_o  = rv_ctrl_pkg::ALU_ADD;
        wb_sel_o  = rv_ctrl_pkg::WB_ALU;
        br_kind_o = rv_ctrl_pkg::BR_NONE;
        wb_en_o   = 1'b0;
        illegal_o = 1'b0;

        case (opcode)
            rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
                wb_en_o = 1'b1;
                if (!is_op) begin
                    op2_sel_o = rv_ctrl_pkg::OP2_IMM_I;
                end
                // funct7 only matters for OP and for the immediate shifts
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        alu_op_o  = (is_op && f7_alt) ? rv_ctrl_pkg::ALU_SUB
                                                      : rv_ctrl_pkg::ALU_ADD;
                        illegal_o = is_op && !f7_base && !f7_alt;
                    end
                    rv_isa_pkg::F3_SLL: begin
                        alu_op_o  = rv_ctrl_pkg::ALU_SLL;
                        illegal_o = !f7_base;
                    end
                    rv_isa_pkg::F3_SRL_SRA: begin
                        alu_op_o  = f7_alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
                        illegal_o = !f7_base && !f7_alt;
                    end
                    rv_isa_pkg::F3_SLT:  alu_op_o = rv_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU: alu_op_o = rv_ctrl_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:  alu_op_o = rv_ctrl_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:   alu_op_o = rv_ctrl_pkg::ALU_OR;
                    default:             alu_op_o = rv_ctrl_pkg::ALU_AND;
                endcase
                if (is_op && !f7_base && funct3 != rv_isa_pkg::F3_ADD_SUB
                    && funct3 != rv_isa_pkg::F3_SRL_SRA) begin
                    illegal_o = 1'b1;
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                op1_sel_o = rv_ctrl_pkg::OP1_IMM_U;
                alu_op_o  = rv_ctrl_pkg::ALU_COPY1;
                wb_en_o   = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                op1_sel_o = rv_ctrl_pkg::OP1_IMM_U;
                op2_sel_o = rv_ctrl_pkg::OP2_PC;
                wb_en_o   = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                wb_sel_o  = rv_ctrl_pkg::WB_PC4;
                br_kind_o = rv_ctrl_pkg::BR_JAL;
                wb_en_o   = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                wb_sel_o  = rv_ctrl_pkg::WB_PC4;
                br_kind_o = rv_ctrl_pkg::BR_JALR;
                wb_en_o   = 1'b1;
                illegal_o = (funct3 != 3'b000);
            end
            rv_isa_pkg::OPC_BRANCH: begin
                case (funct3)
                    rv_isa_pkg::F3_BEQ:  br_kind_o = rv_ctrl_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE:  br_kind_o = rv_ctrl_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT:  br_kind_o = rv_ctrl_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE:  br_kind_o = rv_ctrl_pkg::BR_GE;
                    rv_isa_pkg::F3_BLTU: br_kind_o = rv_ctrl_pkg::BR_LTU;
                    rv_isa_pkg::F3_BGEU: br_kind_o = rv_ctrl_pkg::BR_GEU;
                    default:             illegal_o = 1'b1;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase

        // an illegal word retires as a plain pc+4 with no side effects
        if (illegal_o) begin
            wb_en_o   = 1'b0;
            br_kind_o = rv_ctrl_pkg::BR_NONE;
        end
    end

endmodule

// File: source/rv_ctrl_pkg.sv
// control level encodings passed between the decoders, ALU and commit logic of the core
package rv_ctrl_pkg;

    localparam int XLEN = 32;

    typedef enum logic [1:0] {
        OP1_RS1   = 2'd0,
        OP1_IMM_U = 2'd1
    } op1_sel_e;

    // code 2 is left unassigned
    typedef enum logic [1:0] {
        OP2_PC    = 2'd0,
        OP2_IMM_I = 2'd1,
        OP2_RS2   = 2'd3
    } op2_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY1
    } alu_op_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_PC4 = 1'b1
    } wb_sel_e;

    // nine kinds need four bits
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_kind_e;

endpackage

// File: source/rv_isa_pkg.sv
// RV32I instruction encodings and field layouts, referenced by scope from the decoders
package rv_isa_pkg;

    localparam int REG_ADDR_W = 5;

    // --------------------
    // major opcodes
    // --------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu group funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    // --------------------
    // instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_u_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_j_t;

    // one word, read through whichever format applies
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

endpackage
